//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --timing --assert --timescale 1ns/100ps
TOP       = opfwd_tb
FILELIST  = opfwd.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Errors found

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED, see $(LOG)"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- logic/opfwd_decode.sv
/*
 * opfwd decode stage
 * Instruction register, pipeline freeze generation, register index and
 * immediate extraction, and forwarding select logic
 */
`default_nettype none
`include "opfwd_defines.svh"

module opfwd_decode import opfwd_isa_pkg::*, opfwd_pipe_pkg::*; (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   instr_valid,
	input  instr_u                 instr,
	output logic                   instr_ready,
	input  logic                   ex_valid,
	input  logic                   wb_valid,
	input  logic [`OPFWD_RIDX-1:0] ex_rd,
	input  logic [`OPFWD_RIDX-1:0] wb_rd,
	input  logic                   result_ready,
	output logic [`OPFWD_RIDX-1:0] ra,
	output logic [`OPFWD_RIDX-1:0] rb,
	output logic [`OPFWD_XLEN-1:0] simm,
	output sel_a_e                 sel_a,
	output sel_b_e                 sel_b,
	output logic                   issue_valid,
	output logic [`OPFWD_RIDX-1:0] issue_rd,
	output op_e                    issue_op,
	output logic                   id_freeze,
	output logic                   ex_freeze
);

	logic   id_valid;
	instr_u id_instr;
	logic   is_imm;
	logic   hit_ex_a;
	logic   hit_wb_a;
	logic   hit_ex_b;
	logic   hit_wb_b;

	// Held result at the output stalls everything
	assign ex_freeze   = wb_valid && !result_ready;
	// Empty decode stalls decode alone
	assign id_freeze   = ex_freeze || !id_valid;
	assign instr_ready = !ex_freeze;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_valid <= 1'b0;
		end else if (!ex_freeze) begin
			id_valid <= instr_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!ex_freeze && instr_valid) begin
			id_instr <= instr;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Field extraction

	assign is_imm      = id_instr.i.op[3];
	assign ra          = id_instr.r.ra;
	assign rb          = id_instr.r.rb;
	assign simm        = {{(`OPFWD_XLEN-16){id_instr.i.imm[15]}}, id_instr.i.imm};
	assign issue_valid = id_valid;
	assign issue_rd    = id_instr.r.rd;
	assign issue_op    = id_instr.r.op;

	////////////////////////////////////////////////////////////////////////////
	// Forwarding selects

	// Register 0 never forwards
	assign hit_ex_a = (ra != '0) && ex_valid && (ra == ex_rd);
	assign hit_wb_a = (ra != '0) && wb_valid && (ra == wb_rd);
	assign hit_ex_b = (rb != '0) && ex_valid && (rb == ex_rd);
	assign hit_wb_b = (rb != '0) && wb_valid && (rb == wb_rd);

	// Youngest producer wins
	always_comb begin
		if (hit_ex_a) begin
			sel_a = SEL_A_EX_FORW;
		end else if (hit_wb_a) begin
			sel_a = SEL_A_WB_FORW;
		end else begin
			sel_a = SEL_A_RF;
		end
	end

	always_comb begin
		if (is_imm) begin
			sel_b = SEL_B_IMM;
		end else if (hit_ex_b) begin
			sel_b = SEL_B_EX_FORW;
		end else if (hit_wb_b) begin
			sel_b = SEL_B_WB_FORW;
		end else begin
			sel_b = SEL_B_RF;
		end
	end

	// Stalled output refuses input and keeps decode contents
	a_freeze_holds: assert property (@(posedge clk) disable iff (!arst_n)
		ex_freeze |-> !instr_ready ##1 $stable(id_valid));

endmodule

`default_nettype wire

//--- logic/opfwd_defines.svh
/*
 * opfwd datapath widths
 * Data width, register count and register index width shared by the
 * packages and the RTL of the forwarding datapath
 */
`ifndef OPFWD_DEFINES_SVH
`define OPFWD_DEFINES_SVH

// Width of a data word and of every operand
`define OPFWD_XLEN 32

// Number of architectural registers
// Register 0 always reads zero
`define OPFWD_NREGS 32

// Width of a register index in the instruction word
`define OPFWD_RIDX 5

`endif

//--- logic/opfwd_execute.sv
/*
 * opfwd execute and writeback stages
 * ALU on the operand registers, execute-stage control registers and
 * the writeback register driving the result handshake
 */
`default_nettype none
`include "opfwd_defines.svh"

module opfwd_execute import opfwd_isa_pkg::*, opfwd_pipe_pkg::*; (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   ex_freeze,
	input  logic                   id_freeze,
	input  logic                   issue_valid,
	input  logic [`OPFWD_RIDX-1:0] issue_rd,
	input  op_e                    issue_op,
	input  logic [`OPFWD_XLEN-1:0] operand_a,
	input  logic [`OPFWD_XLEN-1:0] operand_b,
	output logic [`OPFWD_XLEN-1:0] ex_forw,
	output logic [`OPFWD_XLEN-1:0] wb_forw,
	output logic                   ex_valid,
	output logic                   wb_valid,
	output logic [`OPFWD_RIDX-1:0] ex_rd,
	output logic [`OPFWD_RIDX-1:0] wb_rd,
	output logic                   result_valid,
	output result_t                result,
	input  logic                   result_ready,
	output logic                   rf_we
);

	op_e                    ex_op;
	logic [`OPFWD_XLEN-1:0] wb_data;

	////////////////////////////////////////////////////////////////////////////
	// Execute stage

	// Bubble enters when decode is frozen but execute is not
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_valid <= 1'b0;
		end else if (!ex_freeze) begin
			ex_valid <= issue_valid && !id_freeze;
		end
	end

	always_ff @(posedge clk) begin
		if (!ex_freeze && !id_freeze) begin
			ex_rd <= issue_rd;
			ex_op <= issue_op;
		end
	end

	// ALU, its live output is the execute forwarding path
	always_comb begin
		case (ex_op)
			OP_ADD, OP_ADDI: ex_forw = operand_a + operand_b;
			OP_SUB:          ex_forw = operand_a - operand_b;
			OP_AND, OP_ANDI: ex_forw = operand_a & operand_b;
			OP_OR, OP_ORI:   ex_forw = operand_a | operand_b;
			OP_XOR, OP_XORI: ex_forw = operand_a ^ operand_b;
			OP_SHL:          ex_forw = operand_a << operand_b[4:0];
			default:         ex_forw = '0;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Writeback stage

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_valid <= 1'b0;
		end else if (!ex_freeze) begin
			wb_valid <= ex_valid;
		end
	end

	// Payload only moves with a real instruction
	always_ff @(posedge clk) begin
		if (!ex_freeze && ex_valid) begin
			wb_rd   <= ex_rd;
			wb_data <= ex_forw;
		end
	end

	assign wb_forw      = wb_data;
	assign result_valid = wb_valid;
	assign result       = '{rd: wb_rd, value: wb_data};
	// Regfile written on the transfer edge
	assign rf_we        = wb_valid && result_ready;

endmodule

`default_nettype wire

//--- logic/opfwd_isa_pkg.sv
/*
 * opfwd instruction set types
 * Opcode encoding and the one-word instruction, seen either as a
 * register-form or as an immediate-form word
 */
`default_nettype none
`include "opfwd_defines.svh"

package opfwd_isa_pkg;

	// Bit 3 set marks the immediate form
	// Low three bits pick the same ALU function in both forms
	typedef enum logic [3:0] {
		OP_ADD  = 4'h0,
		OP_SUB  = 4'h1,
		OP_AND  = 4'h2,
		OP_OR   = 4'h3,
		OP_XOR  = 4'h4,
		OP_SHL  = 4'h5,
		OP_ADDI = 4'h8,
		OP_ANDI = 4'hA,
		OP_ORI  = 4'hB,
		OP_XORI = 4'hC
	} op_e;

	// Register form, two source registers
	typedef struct packed {
		op_e                    op;
		logic [`OPFWD_RIDX-1:0] rd;
		logic [`OPFWD_RIDX-1:0] ra;
		logic [`OPFWD_RIDX-1:0] rb;
		logic [12:0]            unused;
	} instr_r_t;

	// Immediate form, one source register and a signed 16-bit immediate
	typedef struct packed {
		op_e                    op;
		logic [`OPFWD_RIDX-1:0] rd;
		logic [`OPFWD_RIDX-1:0] ra;
		logic [1:0]             unused;
		logic signed [15:0]     imm;
	} instr_i_t;

	// Same word, decoded both ways by the decode stage
	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

endpackage

`default_nettype wire

//--- logic/opfwd_operand_mux.sv
/*
 * opfwd operand multiplexers
 * Picks each ALU operand from the register file, a forwarding path or
 * the immediate, and holds it in an operand register with a saved flag
 */
`default_nettype none
`include "opfwd_defines.svh"

module opfwd_operand_mux import opfwd_pipe_pkg::*; (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   id_freeze,
	input  logic                   ex_freeze,
	input  logic [`OPFWD_XLEN-1:0] rf_dataa,
	input  logic [`OPFWD_XLEN-1:0] rf_datab,
	input  logic [`OPFWD_XLEN-1:0] ex_forw,
	input  logic [`OPFWD_XLEN-1:0] wb_forw,
	input  logic [`OPFWD_XLEN-1:0] simm,
	input  sel_a_e                 sel_a,
	input  sel_b_e                 sel_b,
	output logic [`OPFWD_XLEN-1:0] operand_a,
	output logic [`OPFWD_XLEN-1:0] operand_b
);

	logic [`OPFWD_XLEN-1:0] muxed_a;
	logic [`OPFWD_XLEN-1:0] muxed_b;
	logic                   saved_a;
	logic                   saved_b;

	// Operand A source
	always_comb begin
		case (sel_a)
			SEL_A_EX_FORW: muxed_a = ex_forw;
			SEL_A_WB_FORW: muxed_a = wb_forw;
			default:       muxed_a = rf_dataa;
		endcase
	end

	// Operand B source
	always_comb begin
		case (sel_b)
			SEL_B_IMM:     muxed_b = simm;
			SEL_B_EX_FORW: muxed_b = ex_forw;
			SEL_B_WB_FORW: muxed_b = wb_forw;
			default:       muxed_b = rf_datab;
		endcase
	end

	// Load while execute advances
	// First load in a decode-only freeze sets saved, later loads blocked
	// Saved clears once decode moves again
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			operand_a <= '0;
			operand_b <= '0;
			saved_a   <= 1'b0;
			saved_b   <= 1'b0;
		end else if (!ex_freeze) begin
			if (!saved_a || !id_freeze) begin
				operand_a <= muxed_a;
			end
			if (!saved_b || !id_freeze) begin
				operand_b <= muxed_b;
			end
			saved_a <= id_freeze;
			saved_b <= id_freeze;
		end
	end

	a_ex_forw_a: assert property (@(posedge clk) disable iff (!arst_n)
		!ex_freeze && !id_freeze && sel_a == SEL_A_EX_FORW |=> operand_a == $past(ex_forw));
	a_wb_forw_b: assert property (@(posedge clk) disable iff (!arst_n)
		!ex_freeze && !id_freeze && sel_b == SEL_B_WB_FORW |=> operand_b == $past(wb_forw));
	a_imm_b: assert property (@(posedge clk) disable iff (!arst_n)
		!ex_freeze && !id_freeze && sel_b == SEL_B_IMM |=> operand_b == $past(simm));

	// Saved flags only rise on an edge where execute moved
	a_saved_rise: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(saved_a) || $rose(saved_b) |-> $past(!ex_freeze));

endmodule

`default_nettype wire

//--- logic/opfwd_pipe_pkg.sv
/*
 * opfwd pipeline types
 * Operand source selects produced by decode and the result word
 * leaving the writeback stage
 */
`default_nettype none
`include "opfwd_defines.svh"

package opfwd_pipe_pkg;

	// Operand A source
	typedef enum logic [1:0] {
		SEL_A_RF      = 2'd0,
		SEL_A_EX_FORW = 2'd2,
		SEL_A_WB_FORW = 2'd3
	} sel_a_e;

	// Operand B source, immediate allowed here only
	typedef enum logic [1:0] {
		SEL_B_RF      = 2'd0,
		SEL_B_IMM     = 2'd1,
		SEL_B_EX_FORW = 2'd2,
		SEL_B_WB_FORW = 2'd3
	} sel_b_e;

	// Writeback result
	// Destination register and value travel together to port and regfile
	typedef struct packed {
		logic [`OPFWD_RIDX-1:0] rd;
		logic [`OPFWD_XLEN-1:0] value;
	} result_t;

endpackage

`default_nettype wire

//--- logic/opfwd_regfile.sv
/*
 * opfwd register file
 * 32 registers, two combinational read ports and one write port
 * Register 0 has no storage and reads zero
 */
`default_nettype none
`include "opfwd_defines.svh"

module opfwd_regfile (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic [`OPFWD_RIDX-1:0] ra,
	input  logic [`OPFWD_RIDX-1:0] rb,
	input  logic [`OPFWD_RIDX-1:0] wa,
	input  logic                   we,
	input  logic [`OPFWD_XLEN-1:0] wd,
	output logic [`OPFWD_XLEN-1:0] rda,
	output logic [`OPFWD_XLEN-1:0] rdb
);

	// Storage for registers 1 to 31 only
	logic [`OPFWD_XLEN-1:0] regs [1:`OPFWD_NREGS-1];

	// Write port, writes to register 0 dropped
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < `OPFWD_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// Read ports
	assign rda = (ra == '0) ? '0 : regs[ra];
	assign rdb = (rb == '0) ? '0 : regs[rb];

	// A write aimed at register 0 leaves port A unchanged
	a_r0_write_ignored: assert property (@(posedge clk) disable iff (!arst_n)
		we && wa == '0 ##1 $stable(ra) |-> $stable(rda));

endmodule

`default_nettype wire

//--- logic/opfwd_top.sv
/*
 * opfwd datapath top
 * Decode, register file, operand mux and execute stages joined
 * between the instruction port and the result port
 */
`default_nettype none
`include "opfwd_defines.svh"

module opfwd_top import opfwd_isa_pkg::*, opfwd_pipe_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	input  logic    instr_valid,
	output logic    instr_ready,
	input  instr_u  instr,
	output logic    result_valid,
	input  logic    result_ready,
	output result_t result
);

	// Decode to regfile and operand mux
	logic [`OPFWD_RIDX-1:0] ra;
	logic [`OPFWD_RIDX-1:0] rb;
	logic [`OPFWD_XLEN-1:0] rf_dataa;
	logic [`OPFWD_XLEN-1:0] rf_datab;
	logic [`OPFWD_XLEN-1:0] simm;
	sel_a_e                 sel_a;
	sel_b_e                 sel_b;
	// Decode to execute
	logic                   issue_valid;
	logic [`OPFWD_RIDX-1:0] issue_rd;
	op_e                    issue_op;
	logic                   id_freeze;
	logic                   ex_freeze;
	logic [`OPFWD_XLEN-1:0] operand_a;
	logic [`OPFWD_XLEN-1:0] operand_b;
	// Forwarding and writeback
	logic [`OPFWD_XLEN-1:0] ex_forw;
	logic [`OPFWD_XLEN-1:0] wb_forw;
	logic                   ex_valid;
	logic                   wb_valid;
	logic [`OPFWD_RIDX-1:0] ex_rd;
	logic [`OPFWD_RIDX-1:0] wb_rd;
	logic                   rf_we;

	opfwd_decode u_decode (.*);

	opfwd_regfile u_regfile (
		.clk, .arst_n, .ra, .rb,
		.wa(result.rd), .we(rf_we), .wd(result.value),
		.rda(rf_dataa), .rdb(rf_datab)
	);

	opfwd_operand_mux u_operand_mux (.*);

	opfwd_execute u_execute (.*);

endmodule

`default_nettype wire

//--- opfwd.f
+incdir+logic
logic/opfwd_isa_pkg.sv
logic/opfwd_pipe_pkg.sv
logic/opfwd_regfile.sv
logic/opfwd_decode.sv
logic/opfwd_operand_mux.sv
logic/opfwd_execute.sv
logic/opfwd_top.sv
tb/opfwd_tb.sv

//--- tb/opfwd_tb.sv
/*
 * opfwd datapath testbench
 * Random instruction stream with input gaps and result back-pressure,
 * checked against an in-order architectural register model
 */
`default_nettype none
`include "opfwd_defines.svh"

module opfwd_tb import opfwd_isa_pkg::*, opfwd_pipe_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_INSTR    = 2000;
	localparam int CYCLE_LIMIT  = 8 * NUM_INSTR + 200;
	localparam int DRAIN_CYCLES = 20;

	// DUT ports
	logic    clk;
	logic    arst_n;
	logic    instr_valid;
	logic    instr_ready;
	instr_u  instr;
	logic    result_valid;
	logic    result_ready;
	result_t result;

	// Model state
	logic [`OPFWD_XLEN-1:0] model_regs [0:`OPFWD_NREGS-1];
	logic [`OPFWD_RIDX-1:0] recent [0:2];
	logic [1:0]             recent_idx;
	op_e                    ops [0:9];
	result_t                expected_q [$];
	// Bookkeeping
	logic [31:0] rng_state;
	logic        instr_taken;
	logic        held;
	result_t     held_result;
	int          accepted;
	int          received;
	int          errors;
	int          cycle_count = 0;

	opfwd_top dut_i (.*);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers

	// Xorshift32 step
	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			$display("** Error %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
			errors++;
		end
	endtask

	task automatic report_failure(input string msg);
		$display("Failure at %0t: %s", $time, msg);
		errors++;
	endtask

	// Sources lean on the last three destinations so forwarding fires often
	function automatic logic [`OPFWD_RIDX-1:0] pick_source();
		logic [31:0] r;
		r = next_rand();
		if (r[1:0] != 2'd3) begin
			return recent[r[1:0]];
		end
		return r[12:8];
	endfunction

	// Destinations mostly in r0..r7 so registers get reused
	function automatic logic [`OPFWD_RIDX-1:0] pick_dest();
		logic [31:0] r;
		r = next_rand();
		if (r[1:0] != 2'd0) begin
			return {2'b00, r[4:2]};
		end
		return r[12:8];
	endfunction

	function automatic instr_u gen_instr();
		instr_u      w;
		logic [31:0] r;
		logic [31:0] idx;
		r      = next_rand();
		idx    = r % 10;
		w      = '0;
		w.r.op = ops[idx[3:0]];
		w.r.rd = pick_dest();
		w.r.ra = pick_source();
		if (w.r.op[3]) begin
			w.i.imm = r[31:16];
		end else begin
			w.r.rb = pick_source();
		end
		return w;
	endfunction

	// Architectural step
	// Register 0 is never written
	task automatic model_execute(input instr_u w);
		logic [`OPFWD_XLEN-1:0] a;
		logic [`OPFWD_XLEN-1:0] b;
		logic [`OPFWD_XLEN-1:0] v;
		result_t                exp;
		a = model_regs[w.r.ra];
		if (w.r.op[3]) begin
			b = {{(`OPFWD_XLEN-16){w.i.imm[15]}}, w.i.imm};
		end else begin
			b = model_regs[w.r.rb];
		end
		case (w.r.op)
			OP_ADD, OP_ADDI: v = a + b;
			OP_SUB:          v = a - b;
			OP_AND, OP_ANDI: v = a & b;
			OP_OR, OP_ORI:   v = a | b;
			OP_XOR, OP_XORI: v = a ^ b;
			OP_SHL:          v = a << b[4:0];
			default:         v = '0;
		endcase
		exp.rd    = w.r.rd;
		exp.value = v;
		expected_q.push_back(exp);
		if (w.r.rd != '0) begin
			model_regs[w.r.rd] = v;
		end
		recent[recent_idx] = w.r.rd;
		recent_idx = (recent_idx == 2'd2) ? 2'd0 : recent_idx + 2'd1;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// One clock cycle of traffic

	// Drive on the falling edge and sample what the next rising edge sees
	task automatic run_cycle(input logic feed);
		logic [31:0] r;
		result_t     exp;
		@(negedge clk);
		r = next_rand();
		// Offered word holds until taken
		if (!instr_valid || instr_taken) begin
			if (feed && accepted < NUM_INSTR && r[1:0] != 2'd0) begin
				instr_valid = 1'b1;
				instr       = gen_instr();
			end else begin
				instr_valid = 1'b0;
			end
		end
		result_ready = feed ? (r[3:2] != 2'd0) : 1'b1;
		#1;
		instr_taken = instr_valid && instr_ready;
		if (instr_taken) begin
			model_execute(instr);
			accepted++;
		end
		// Result refused last edge must still be offered unchanged
		if (held) begin
			check_value("result_valid", 64'(result_valid), 64'd1);
			check_value("result", 64'(result), 64'(held_result));
		end
		if (result_valid && !result_ready) begin
			check_value("instr_ready", 64'(instr_ready), 64'd0);
		end
		held        = result_valid && !result_ready;
		held_result = result;
		// Every delivered result is counted, expected or not
		if (result_valid && result_ready) begin
			if (expected_q.size() == 0) begin
				report_failure("a result was delivered with no instruction outstanding");
			end else begin
				exp = expected_q.pop_front();
				check_value("result", 64'(result), 64'(exp));
			end
			received++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		rng_state    = 32'h3447_b5a3;
		clk          = 1'b0;
		arst_n       = 1'b0;
		instr_valid  = 1'b0;
		instr        = '0;
		result_ready = 1'b0;
		instr_taken  = 1'b0;
		held         = 1'b0;
		held_result  = '0;
		recent_idx   = 2'd0;
		accepted     = 0;
		received     = 0;
		errors       = 0;
		ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL,
			OP_ADDI, OP_ANDI, OP_ORI, OP_XORI};
		for (int i = 0; i < `OPFWD_NREGS; i++) begin
			model_regs[i] = '0;
		end
		for (int i = 0; i < 3; i++) begin
			recent[i] = '0;
		end
		// Reset for 10 cycles with the port idle but ready
		repeat (10) begin
			@(negedge clk);
			#1;
			check_value("result_valid", 64'(result_valid), 64'd0);
			check_value("instr_ready", 64'(instr_ready), 64'd1);
		end
		arst_n = 1'b1;
		// First cycle out of reset
		@(negedge clk);
		#1;
		check_value("result_valid", 64'(result_valid), 64'd0);
		check_value("instr_ready", 64'(instr_ready), 64'd1);

		while (received < NUM_INSTR) begin
			run_cycle(1'b1);
		end
		// Quiet tail catches duplicated results
		repeat (DRAIN_CYCLES) begin
			run_cycle(1'b0);
		end
		check_value("result_count", 64'(received), 64'(NUM_INSTR));
		check_value("pending_results", 64'(expected_q.size()), 64'd0);

		$display("Run complete: %0d accepted, %0d results, %0d errors",
			accepted, received, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	// Watchdog on the cycle counter
	initial begin
		wait (cycle_count >= CYCLE_LIMIT);
		$display("Timeout after %0d cycles: results stopped arriving, %0d of %0d received",
			cycle_count, received, NUM_INSTR);
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire
